// ==== common/er_cfg.svh ====
`ifndef ER_CFG_SVH
`define ER_CFG_SVH

// word widths
`define ER_WORD_W       32
`define ER_STATE_W      16
`define ER_ADDR_W       8
`define ER_CNT_W        16

// host state codes
`define ER_RUN_CODE     16'd8      // engines may start
`define ER_DONE_CODE    16'd8888   // both engines finished

// start sequencer counts
`define ER_START_A_CNT  16'd128    // alice goes first
`define ER_START_B_CNT  16'd252    // bob a while later
`define ER_START_SAT    16'd255    // counter parks here

// storage depths, powers of two
`define ER_LOG_DEPTH    16
`define ER_FIFO_DEPTH   16

// apb byte addresses
`define ER_ADDR_STATE   8'h00
`define ER_ADDR_STATUS  8'h04
`define ER_ADDR_LOGCNT  8'h08
`define ER_ADDR_LOG     8'h40
`define ER_LOG_STRIDE   8          // bytes per log entry

`endif

// ==== common/er_pkg.sv ====
`include "er_cfg.svh"

package er_pkg;

    // channel data, log fields, apb data
    typedef logic [`ER_WORD_W-1:0] er_word_t;

    // host visible state word
    typedef logic [`ER_STATE_W-1:0] er_state_t;

    // apb byte address
    typedef logic [`ER_ADDR_W-1:0] apb_addr_t;

    // start sequencer count
    typedef logic [`ER_CNT_W-1:0] start_cnt_t;

    // one entry of the frame log
    typedef logic [$clog2(`ER_LOG_DEPTH)-1:0] log_idx_t;

endpackage

// ==== er_ctrl/er_apb_regs.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_apb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  er_pkg::apb_addr_t paddr,
    input  er_pkg::er_word_t  pwdata,
    output er_pkg::er_word_t  prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              a_finish_pulse,
    input  logic              b_finish_pulse,
    input  er_pkg::er_word_t  log_count,
    input  er_pkg::er_word_t  log_leaked,
    input  er_pkg::er_word_t  log_error,
    output logic              run,
    output er_pkg::log_idx_t  log_rd_idx
);
    import er_pkg::*;

    localparam int LOG_BYTES = `ER_LOG_DEPTH * `ER_LOG_STRIDE;  // size of log window
    localparam int FIELD_BIT = $clog2(`ER_LOG_STRIDE) - 1;      // picks error field

    er_state_t state_word;
    logic      a_finish;
    logic      b_finish;
    logic      both_done;
    logic      access;      // apb access phase
    logic      is_state;
    logic      is_status;
    logic      is_logcnt;
    logic      in_log;
    logic      mapped;
    logic      read_only;
    apb_addr_t log_off;     // byte offset into log window

    assign pready    = 1'b1;  // never stalls
    assign access    = psel & penable;
    assign both_done = a_finish & b_finish;

    // address decode
    assign is_state  = (paddr == `ER_ADDR_STATE);
    assign is_status = (paddr == `ER_ADDR_STATUS);
    assign is_logcnt = (paddr == `ER_ADDR_LOGCNT);
    assign log_off   = paddr - `ER_ADDR_LOG;
    assign in_log    = (paddr >= `ER_ADDR_LOG) && (log_off < LOG_BYTES) && (paddr[1:0] == 2'b00);
    assign mapped    = is_state | is_status | is_logcnt | in_log;
    assign read_only = is_status | is_logcnt | in_log;

    assign log_rd_idx = log_idx_t'(log_off >> $clog2(`ER_LOG_STRIDE));  // entry number

    // error in the access phase only
    assign pslverr = access & (~mapped | (pwrite & read_only));

    // sticky finish flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_finish <= 1'b0;
            b_finish <= 1'b0;
        end else begin
            a_finish <= a_finish | a_finish_pulse;
            b_finish <= b_finish | b_finish_pulse;
        end
    end

    // state word, completion code wins over host writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_word <= '0;
        end else if (both_done) begin
            state_word <= `ER_DONE_CODE;
        end else if (access && pwrite && is_state) begin
            state_word <= er_state_t'(pwdata);  // low half only
        end
    end

    // run follows state one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= (state_word == `ER_RUN_CODE) && !both_done;  // drops with done code
        end
    end

    // read mux
    always_comb begin
        prdata = '0;
        if (is_state) begin
            prdata = er_word_t'(state_word);
        end else if (is_status) begin
            prdata = er_word_t'({b_finish, a_finish});  // bit0 alice, bit1 bob
        end else if (is_logcnt) begin
            prdata = log_count;
        end else if (in_log) begin
            prdata = log_off[FIELD_BIT] ? log_error : log_leaked;  // +4 is error count
        end
    end

endmodule

// ==== er_ctrl/er_start_seq.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_start_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic start_a,
    output logic start_b
);
    import er_pkg::*;

    start_cnt_t start_cnt;
    logic       at_sat;

    assign at_sat = (start_cnt == `ER_START_SAT);

    // counts while run is high, parks at saturation until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= '0;
        end else if (!at_sat && run) begin
            start_cnt <= start_cnt + 1'b1;
        end
    end

    // single cycle strobes
    assign start_a = (start_cnt == `ER_START_A_CNT);  // alice first
    assign start_b = (start_cnt == `ER_START_B_CNT);  // bob after the gap

endmodule

// ==== source/er_frame_log.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_frame_log (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_valid,
    input  er_pkg::er_word_t leaked_info,
    input  er_pkg::er_word_t error_count,
    input  er_pkg::log_idx_t log_rd_idx,
    output er_pkg::er_word_t log_leaked,
    output er_pkg::er_word_t log_error,
    output er_pkg::er_word_t log_count
);
    import er_pkg::*;

    er_word_t leaked_mem [`ER_LOG_DEPTH];  // leaked info per frame
    er_word_t error_mem  [`ER_LOG_DEPTH];  // error count per frame
    log_idx_t wr_ptr;

    // pointer and frame counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            log_count <= '0;
        end else if (frame_valid) begin
            if (wr_ptr == log_idx_t'(`ER_LOG_DEPTH - 1)) begin
                wr_ptr <= '0;  // wrap, oldest entry goes next
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            log_count <= log_count + 1'b1;  // rolls over at 2^32
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            leaked_mem[wr_ptr] <= leaked_info;
            error_mem[wr_ptr]  <= error_count;
        end
    end

    // read port straight from the array
    assign log_leaked = leaked_mem[log_rd_idx];
    assign log_error  = error_mem[log_rd_idx];

endmodule

// ==== source/er_fifo.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_fifo #(
    parameter int DEPTH = `ER_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  er_pkg::er_word_t din,
    output logic             full,
    output logic             wr_ack,
    input  logic             rd_en,
    output er_pkg::er_word_t dout,
    output logic             valid,
    output logic             empty
);
    import er_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
    localparam int CW = $clog2(DEPTH + 1);                // count holds 0..DEPTH

    er_word_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;     // words held
    logic            do_wr;
    logic            do_rd;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en & ~full;   // dropped when full
    assign do_rd = rd_en & ~empty;  // ignored when empty

    // pointers, occupancy and handshake flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            valid  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CW'(do_wr) - CW'(do_rd);
            wr_ack <= do_wr;  // one cycle after wr_en
            valid  <= do_rd;  // lines up with dout
        end
    end

    // storage and registered read data
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== source/er_link_top.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_link_top (
    input  logic              clk,
    input  logic              rst_n,
    // apb slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  er_pkg::apb_addr_t paddr,
    input  er_pkg::er_word_t  pwdata,
    output er_pkg::er_word_t  prdata,
    output logic              pready,
    output logic              pslverr,
    // engine control
    output logic              start_a,
    output logic              start_b,
    input  logic              a_finish_pulse,
    input  logic              b_finish_pulse,
    input  logic              frame_valid,
    input  er_pkg::er_word_t  leaked_info,
    input  er_pkg::er_word_t  error_count,
    // alice to bob
    input  logic              a2b_wr_en,
    input  er_pkg::er_word_t  a2b_din,
    output logic              a2b_full,
    output logic              a2b_wr_ack,
    input  logic              a2b_rd_en,
    output er_pkg::er_word_t  a2b_dout,
    output logic              a2b_valid,
    output logic              a2b_empty,
    // bob to alice
    input  logic              b2a_wr_en,
    input  er_pkg::er_word_t  b2a_din,
    output logic              b2a_full,
    output logic              b2a_wr_ack,
    input  logic              b2a_rd_en,
    output er_pkg::er_word_t  b2a_dout,
    output logic              b2a_valid,
    output logic              b2a_empty
);
    import er_pkg::*;

    logic     run;          // regs to sequencer
    log_idx_t log_rd_idx;   // regs to log
    er_word_t log_count;
    er_word_t log_leaked;
    er_word_t log_error;

    er_apb_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .a_finish_pulse (a_finish_pulse),
        .b_finish_pulse (b_finish_pulse),
        .log_count      (log_count),
        .log_leaked     (log_leaked),
        .log_error      (log_error),
        .run            (run),
        .log_rd_idx     (log_rd_idx)
    );

    er_start_seq u_start (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .start_a (start_a),
        .start_b (start_b)
    );

    er_frame_log u_log (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .leaked_info (leaked_info),
        .error_count (error_count),
        .log_rd_idx  (log_rd_idx),
        .log_leaked  (log_leaked),
        .log_error   (log_error),
        .log_count   (log_count)
    );

    // alice writes, bob reads
    er_fifo #(.DEPTH(`ER_FIFO_DEPTH)) u_a2b_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (a2b_wr_en),
        .din    (a2b_din),
        .full   (a2b_full),
        .wr_ack (a2b_wr_ack),
        .rd_en  (a2b_rd_en),
        .dout   (a2b_dout),
        .valid  (a2b_valid),
        .empty  (a2b_empty)
    );

    // bob writes, alice reads
    er_fifo #(.DEPTH(`ER_FIFO_DEPTH)) u_b2a_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (b2a_wr_en),
        .din    (b2a_din),
        .full   (b2a_full),
        .wr_ack (b2a_wr_ack),
        .rd_en  (b2a_rd_en),
        .dout   (b2a_dout),
        .valid  (b2a_valid),
        .empty  (b2a_empty)
    );

endmodule

// ==== dv/er_link_tb.sv ====
`timescale 1ns/1ns
`include "er_cfg.svh"

module er_link_tb;
    import er_pkg::*;

    localparam int          HALF_PERIOD  = 20;
    localparam int          PERIOD       = 2 * HALF_PERIOD;
    localparam int          RESET_CYCLES = 3;
    localparam int unsigned SEED         = 32'h1dbadce5;
    localparam int          DEPTH        = `ER_FIFO_DEPTH;
    localparam int          FRAMES       = 20;   // wraps the 16 entry log
    localparam int          ORDER_WORDS  = 10;
    localparam int          SEQ_WATCH    = 320;  // runs well past saturation at 255

    // cycle budget of each test in clock cycles
    localparam int APB_LEN    = 3;  // setup, access, idle
    localparam int REGS_LEN   = 10 * APB_LEN;
    localparam int START_LEN  = APB_LEN + SEQ_WATCH;
    localparam int FINISH_LEN = 4 + 6 * APB_LEN;
    localparam int LOG_LEN    = FRAMES + 1 + (2 * `ER_LOG_DEPTH + 1) * APB_LEN;
    localparam int ORDER_LEN  = 2 * ORDER_WORDS * 4;
    localparam int BP_LEN     = (2 * DEPTH + 2) * 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + REGS_LEN + START_LEN + FINISH_LEN
                                   + LOG_LEN + ORDER_LEN + BP_LEN + 100;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    er_word_t  pwdata;
    er_word_t  prdata;
    logic      pready;
    logic      pslverr;
    logic      start_a;
    logic      start_b;
    logic      a_finish_pulse;
    logic      b_finish_pulse;
    logic      frame_valid;
    er_word_t  leaked_info;
    er_word_t  error_count;
    logic      a2b_wr_en;
    logic      a2b_full;
    logic      a2b_wr_ack;
    logic      a2b_rd_en;
    logic      a2b_valid;
    logic      a2b_empty;
    er_word_t  a2b_din;
    er_word_t  a2b_dout;
    logic      b2a_wr_en;
    logic      b2a_full;
    logic      b2a_wr_ack;
    logic      b2a_rd_en;
    logic      b2a_valid;
    logic      b2a_empty;
    er_word_t  b2a_din;
    er_word_t  b2a_dout;

    string     cur_test;
    int        test_errs;
    int        checks;
    int        errors;
    int        tests_run;
    int        tests_failed;
    er_word_t  exp_q [$];                // words in flight on a channel
    er_word_t  frame_leaked [FRAMES];    // log stimulus kept for readback
    er_word_t  frame_error  [FRAMES];

    er_link_top DUT (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("error %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, test_errs);
        end else begin
            $display("test %s ok", cur_test);
        end
    endtask

    // one apb transfer without wait states
    task automatic apb_access(input bit write, input apb_addr_t addr, input er_word_t wdata,
                              output er_word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;  // access phase
        #(HALF_PERIOD / 2);
        rdata = prdata;
        err   = pslverr;
        check_eq("pready", 1'b1, pready);  // no wait states expected
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_read(input apb_addr_t addr, input er_word_t exp, input string what);
        er_word_t rdata;
        logic     err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_eq({what, " data"}, exp, rdata);
        check_eq({what, " pslverr"}, 1'b0, err);
    endtask

    task automatic reg_write(input apb_addr_t addr, input er_word_t data, input logic exp_err,
                             input string what);
        er_word_t rdata;
        logic     err;
        apb_access(1'b1, addr, data, rdata, err);
        check_eq({what, " pslverr"}, exp_err, err);
    endtask

    // channel writer on the engine side
    task automatic chan_write(input bit b2a, input er_word_t data, input logic exp_ack);
        @(negedge clk);
        if (b2a) begin
            b2a_wr_en = 1'b1;
            b2a_din   = data;
        end else begin
            a2b_wr_en = 1'b1;
            a2b_din   = data;
        end
        @(negedge clk);
        check_eq("wr_ack", exp_ack, b2a ? b2a_wr_ack : a2b_wr_ack);  // one cycle after wr_en
        a2b_wr_en = 1'b0;
        b2a_wr_en = 1'b0;
    endtask

    // channel reader on the engine side
    task automatic chan_read(input bit b2a, input logic exp_valid, input er_word_t exp_data);
        @(negedge clk);
        if (b2a) begin
            b2a_rd_en = 1'b1;
        end else begin
            a2b_rd_en = 1'b1;
        end
        @(negedge clk);
        check_eq("valid", exp_valid, b2a ? b2a_valid : a2b_valid);
        if (exp_valid) begin
            check_eq("dout", exp_data, b2a ? b2a_dout : a2b_dout);
        end
        a2b_rd_en = 1'b0;
        b2a_rd_en = 1'b0;
    endtask

    task automatic pulse_finish(input bit bob);
        @(negedge clk);
        a_finish_pulse = !bob;
        b_finish_pulse = bob;
        @(negedge clk);
        a_finish_pulse = 1'b0;
        b_finish_pulse = 1'b0;
    endtask

    initial begin
        er_word_t rdata;
        logic     err;
        er_word_t word;
        int       newest;
        void'($urandom(SEED));
        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        a_finish_pulse = 1'b0;
        b_finish_pulse = 1'b0;
        frame_valid = 1'b0;
        leaked_info = '0;
        error_count = '0;
        {a2b_wr_en, a2b_rd_en, a2b_din} = '0;
        {b2a_wr_en, b2a_rd_en, b2a_din} = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_and_regs");
        check_eq("idle outputs", '0, {start_a, start_b, pslverr, a2b_wr_ack, a2b_valid,
                                      a2b_full, b2a_wr_ack, b2a_valid, b2a_full});
        check_eq("empty flags", 2'b11, {a2b_empty, b2a_empty});
        reg_read(`ER_ADDR_STATE, '0, "state");
        reg_read(`ER_ADDR_STATUS, '0, "status");
        reg_read(`ER_ADDR_LOGCNT, '0, "logcnt");
        reg_write(`ER_ADDR_STATE, 32'h1234, 1'b0, "state write");
        reg_read(`ER_ADDR_STATE, 32'h1234, "state readback");
        apb_access(1'b0, 8'h0c, '0, rdata, err);  // hole between logcnt and log
        check_eq("unmapped pslverr", 1'b1, err);
        reg_write(`ER_ADDR_STATUS, 32'h3, 1'b1, "status write");
        reg_read(`ER_ADDR_STATUS, '0, "status untouched");
        end_test();

        begin_test("start_timing");
        reg_write(`ER_ADDR_STATE, `ER_RUN_CODE, 1'b0, "run write");
        // run rises one cycle after the write and the strobes follow at fixed counts
        for (int i = 1; i <= SEQ_WATCH; i++) begin
            @(negedge clk);
            check_eq($sformatf("start_a cycle %0d", i), i == 1 + `ER_START_A_CNT, start_a);
            check_eq($sformatf("start_b cycle %0d", i), i == 1 + `ER_START_B_CNT, start_b);
        end
        end_test();

        begin_test("finish_done");
        pulse_finish(1'b0);
        reg_read(`ER_ADDR_STATUS, 32'h1, "status after alice");
        reg_read(`ER_ADDR_STATE, `ER_RUN_CODE, "state after alice");
        pulse_finish(1'b1);
        reg_read(`ER_ADDR_STATUS, 32'h3, "status after bob");
        reg_read(`ER_ADDR_STATE, `ER_DONE_CODE, "state after bob");
        reg_write(`ER_ADDR_STATE, 32'h55, 1'b0, "late host write");
        reg_read(`ER_ADDR_STATE, `ER_DONE_CODE, "state held");
        end_test();

        begin_test("frame_log");
        for (int f = 0; f < FRAMES; f++) begin
            @(negedge clk);
            frame_valid     = 1'b1;  // back to back frames
            leaked_info     = $urandom();
            error_count     = $urandom();
            frame_leaked[f] = leaked_info;
            frame_error[f]  = error_count;
        end
        @(negedge clk);
        frame_valid = 1'b0;
        reg_read(`ER_ADDR_LOGCNT, FRAMES, "logcnt");
        for (int i = 0; i < `ER_LOG_DEPTH; i++) begin
            // newest frame that landed here after the wrap
            newest = i + `ER_LOG_DEPTH * ((FRAMES - 1 - i) / `ER_LOG_DEPTH);
            reg_read(apb_addr_t'(`ER_ADDR_LOG + `ER_LOG_STRIDE * i), frame_leaked[newest],
                     $sformatf("leaked entry %0d", i));
            reg_read(apb_addr_t'(`ER_ADDR_LOG + `ER_LOG_STRIDE * i + 4), frame_error[newest],
                     $sformatf("errors entry %0d", i));
        end
        end_test();

        begin_test("channel_order");
        for (int d = 0; d < 2; d++) begin
            exp_q.delete();
            for (int n = 0; n < ORDER_WORDS; n++) begin
                word = $urandom();
                exp_q.push_back(word);
                chan_write(d == 1, word, 1'b1);
            end
            while (exp_q.size() > 0) begin
                chan_read(d == 1, 1'b1, exp_q.pop_front());  // oldest first
            end
        end
        end_test();

        begin_test("channel_backpressure");
        exp_q.delete();
        for (int n = 0; n < DEPTH; n++) begin
            word = $urandom();
            exp_q.push_back(word);
            chan_write(1'b0, word, 1'b1);
        end
        check_eq("a2b_full", 1'b1, a2b_full);
        chan_write(1'b0, $urandom(), 1'b0);  // dropped without an ack
        check_eq("a2b_full after drop", 1'b1, a2b_full);
        for (int n = 0; n < DEPTH; n++) begin
            chan_read(1'b0, 1'b1, exp_q.pop_front());
        end
        check_eq("a2b_empty", 1'b1, a2b_empty);
        chan_read(1'b0, 1'b0, '0);  // nothing left
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== er_link_top.f ====
+incdir+common
common/er_pkg.sv
er_ctrl/er_apb_regs.sv
er_ctrl/er_start_seq.sv
source/er_frame_log.sv
source/er_fifo.sv
source/er_link_top.sv
dv/er_link_tb.sv
